// File: verilog/fft_pkg.sv
package fft_pkg;

    // ********************************************************************
    // Transform size and widths.
    // ********************************************************************
    localparam int N_POINTS = 16;             // Complex samples in memory.
    localparam int ADDR_W   = 4;              // Sample address width.
    localparam int DATA_W   = 16;             // One component, Q1.15.
    localparam int STAGE_W  = 2;              // Stage number 0 to 3.
    localparam int CNT_W    = 4;              // Butterfly counter width.
    localparam int TW_N     = N_POINTS / 2;   // Twiddle table depth.

    // Products and the scaled twiddle product need extra headroom.
    localparam int PROD_W   = 2 * DATA_W + 1;
    localparam int T_W      = DATA_W + 2;

    // ********************************************************************
    // Wishbone word address map.
    // ********************************************************************
    localparam int WB_ADR_W = 5;
    localparam int WB_DAT_W = 32;

    localparam logic [WB_ADR_W-1:0] ADR_CTRL   = 5'd16;
    localparam logic [WB_ADR_W-1:0] ADR_STATUS = 5'd17;

    // Imaginary part sits in the upper half of the bus word.
    typedef struct packed {
        logic signed [DATA_W-1:0] im;
        logic signed [DATA_W-1:0] re;
    } cplx_t;

    // W(j) = cos(2*pi*j/16) - i*sin(2*pi*j/16), Q1.15.
    localparam logic signed [DATA_W-1:0] TW_COS [TW_N] = '{
        16'sd32767,  16'sd30274,  16'sd23170,  16'sd12540,
        16'sd0,     -16'sd12540, -16'sd23170, -16'sd30274
    };

    localparam logic signed [DATA_W-1:0] TW_SIN [TW_N] = '{
        16'sd0,      16'sd12540,  16'sd23170,  16'sd30274,
        16'sd32767,  16'sd30274,  16'sd23170,  16'sd12540
    };

endpackage

// File: verilog/pair_mem_if.sv
`timescale 1ns/1ps

interface pair_mem_if import fft_pkg::*; ();

    // Pair write, element a first and element b one cycle later.
    logic              wr_start;
    logic [ADDR_W-1:0] wr_addr_a;
    logic [ADDR_W-1:0] wr_addr_b;
    cplx_t             wr_data_a;
    cplx_t             wr_data_b;

    // Two consecutive reads form one pair.
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    cplx_t             rd_pair_a;
    cplx_t             rd_pair_b;
    logic              pair_valid;

    modport user (
        output wr_start, wr_addr_a, wr_addr_b, wr_data_a, wr_data_b,
        output rd_en, rd_addr,
        input  rd_pair_a, rd_pair_b, pair_valid
    );

    modport ram (
        input  wr_start, wr_addr_a, wr_addr_b, wr_data_a, wr_data_b,
        input  rd_en, rd_addr,
        output rd_pair_a, rd_pair_b, pair_valid
    );

endinterface

// File: verilog/stage_ctrl_if.sv
`timescale 1ns/1ps

interface stage_ctrl_if import fft_pkg::*; ();

    // ********************************************************************
    // Stage control.
    // ********************************************************************
    logic               start;        // One-cycle pulse.
    logic [STAGE_W-1:0] stage;
    logic               busy;         // Stage in progress.

    // ********************************************************************
    // Host sample access, held until granted.
    // ********************************************************************
    logic               host_req;
    logic               host_we;
    logic [ADDR_W-1:0]  host_addr;
    cplx_t              host_wdata;
    logic               host_ack;
    cplx_t              host_rdata;

    modport decode (
        output start, stage,
        output host_req, host_we, host_addr, host_wdata,
        input  host_ack, host_rdata, busy
    );

    modport execute (
        input  start, stage,
        input  host_req, host_we, host_addr, host_wdata,
        output host_ack, host_rdata, busy
    );

endinterface

// File: verilog/fft_wb_decode.sv
`timescale 1ns/1ps

module fft_wb_decode import fft_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [WB_ADR_W-1:0] wb_adr_i,
    input  logic [WB_DAT_W-1:0] wb_dat_i,
    output logic [WB_DAT_W-1:0] wb_dat_o,
    output logic                wb_ack_o,
    stage_ctrl_if.decode        ctrl,
    input  logic                done_i,
    input  logic [CNT_W-1:0]    bfly_count_i,
    output logic                clr_done_o
);

    logic                access;
    logic                sample_hit;
    logic [WB_DAT_W-1:0] reg_rdata;
    logic                ack_q;
    logic                start_q;
    logic                clr_q;
    logic                req_q;
    logic [STAGE_W-1:0]  stage_q;
    logic                we_q;
    logic [ADDR_W-1:0]   addr_q;
    cplx_t               wdata_q;
    logic [WB_DAT_W-1:0] dat_q;

    assign access     = wb_cyc_i && wb_stb_i && !ack_q;  // Open cycle, not yet answered.
    assign sample_hit = !wb_adr_i[WB_ADR_W-1];           // Words 0 to 15.

    always_comb begin
        case (wb_adr_i)
            ADR_CTRL:   reg_rdata = WB_DAT_W'({stage_q, 1'b0});
            ADR_STATUS: reg_rdata = WB_DAT_W'({bfly_count_i, 2'b00, done_i, ctrl.busy});
            default:    reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            start_q <= 1'b0;
            clr_q   <= 1'b0;
            req_q   <= 1'b0;
            stage_q <= '0;
        end else begin
            ack_q   <= 1'b0;
            start_q <= 1'b0;
            clr_q   <= 1'b0;
            if (req_q) begin
                // Sample access waits for the engine.
                if (ctrl.host_ack) begin
                    req_q <= 1'b0;
                    ack_q <= 1'b1;
                end
            end else if (access && sample_hit) begin
                req_q <= 1'b1;
            end else if (access) begin
                ack_q <= 1'b1;                         // Registers answer in one cycle.
                if (wb_we_i && wb_adr_i == ADR_CTRL && wb_dat_i[0]) begin
                    start_q <= 1'b1;
                    stage_q <= wb_dat_i[2:1];
                end
                if (wb_we_i && wb_adr_i == ADR_STATUS && wb_dat_i[0])
                    clr_q <= 1'b1;                     // Write 1 clears done.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!req_q && access && sample_hit) begin
            we_q    <= wb_we_i;
            addr_q  <= wb_adr_i[ADDR_W-1:0];
            wdata_q <= wb_dat_i;
        end
        if (req_q && ctrl.host_ack)
            dat_q <= ctrl.host_rdata;
        else if (access && !sample_hit)
            dat_q <= reg_rdata;
    end

    assign ctrl.start      = start_q;
    assign ctrl.stage      = stage_q;
    assign ctrl.host_req   = req_q;
    assign ctrl.host_we    = we_q;
    assign ctrl.host_addr  = addr_q;
    assign ctrl.host_wdata = wdata_q;
    assign wb_ack_o        = ack_q;
    assign wb_dat_o        = dat_q;
    assign clr_done_o      = clr_q;

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i));

endmodule

// File: verilog/pair_ram.sv
`timescale 1ns/1ps

module pair_ram import fft_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    pair_mem_if.ram mem
);

    typedef enum logic {
        RD_FIRST,
        RD_SECOND
    } rd_state_t;

    cplx_t             ram_q [N_POINTS];
    logic              wr_second_q;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    cplx_t             wr_data;
    cplx_t             rd_word_q;
    cplx_t             first_q;
    rd_state_t         rd_state_q;
    logic              valid_q;

    // ********************************************************************
    // Pair write over two cycles.
    // ********************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wr_second_q <= 1'b0;
        else
            wr_second_q <= mem.wr_start;
    end

    assign wr_en   = mem.wr_start || wr_second_q;
    assign wr_addr = mem.wr_start ? mem.wr_addr_a : mem.wr_addr_b;
    assign wr_data = mem.wr_start ? mem.wr_data_a : mem.wr_data_b;

    always_ff @(posedge clk) begin
        if (wr_en)
            ram_q[wr_addr] <= wr_data;
        if (mem.rd_en)
            rd_word_q <= ram_q[mem.rd_addr];
    end

    // Read FSM. First word is parked while the second one is fetched.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state_q <= RD_FIRST;
            valid_q    <= 1'b0;
        end else begin
            valid_q <= (rd_state_q == RD_SECOND);
            case (rd_state_q)
                RD_FIRST:  if (mem.rd_en) rd_state_q <= RD_SECOND;
                RD_SECOND: rd_state_q <= RD_FIRST;
                default:   rd_state_q <= RD_FIRST;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_state_q == RD_SECOND)
            first_q <= rd_word_q;
    end

    assign mem.rd_pair_a  = first_q;
    assign mem.rd_pair_b  = rd_word_q;
    assign mem.pair_valid = valid_q;

    a_no_back_to_back_wr: assert property (@(posedge clk) disable iff (!rst_n)
        mem.wr_start |=> !mem.wr_start);

endmodule

// File: verilog/bfly_execute.sv
`timescale 1ns/1ps

module bfly_execute import fft_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    stage_ctrl_if.execute ctrl,
    output logic          bfly_done_o,
    output logic          stage_end_o
);

    typedef enum logic [3:0] {
        S_IDLE, S_RDA, S_RDB, S_WAIT, S_MUL, S_WR1, S_WR2,
        S_HWR1, S_HWR2, S_HRD1, S_HRD2, S_HRDV
    } state_t;

    state_t                   state_q;
    logic [STAGE_W-1:0]       stage_q;
    logic [ADDR_W-2:0]        pair_q;
    logic                     stage_run;
    logic [ADDR_W-1:0]        half;
    logic [ADDR_W-1:0]        k;
    logic [ADDR_W-1:0]        addr_a;
    logic [ADDR_W-1:0]        addr_b;
    logic [ADDR_W-2:0]        tw_idx;
    logic signed [DATA_W-1:0] tw_c;
    logic signed [DATA_W-1:0] tw_s;
    cplx_t                    a_q;
    cplx_t                    b_q;
    logic signed [PROD_W-1:0] pr_re;
    logic signed [PROD_W-1:0] pr_im;
    logic signed [T_W-1:0]    t_re_q;
    logic signed [T_W-1:0]    t_im_q;
    logic signed [T_W:0]      sum_re;
    logic signed [T_W:0]      sum_im;
    logic signed [T_W:0]      dif_re;
    logic signed [T_W:0]      dif_im;
    cplx_t                    new_a;
    cplx_t                    new_b;

    pair_mem_if mem ();

    pair_ram u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (mem)
    );

    // ********************************************************************
    // Butterfly addressing for the current stage.
    // ********************************************************************
    assign half   = ADDR_W'(1) << stage_q;
    assign k      = {1'b0, pair_q} & (half - 1'b1);
    assign addr_a = (({1'b0, pair_q} >> stage_q) << ({1'b0, stage_q} + 3'd1)) + k;
    assign addr_b = addr_a + half;
    assign tw_idx = (ADDR_W-1)'(k << (STAGE_W'(ADDR_W - 1) - stage_q)); // k*8/half.
    assign tw_c   = TW_COS[tw_idx];
    assign tw_s   = TW_SIN[tw_idx];

    // (c - i*s) * (br + i*bi).
    assign pr_re = tw_c * b_q.re + tw_s * b_q.im;
    assign pr_im = tw_c * b_q.im - tw_s * b_q.re;

    assign sum_re   = a_q.re + t_re_q;
    assign sum_im   = a_q.im + t_im_q;
    assign dif_re   = a_q.re - t_re_q;
    assign dif_im   = a_q.im - t_im_q;
    assign new_a.re = DATA_W'(sum_re >>> 1);     // Halved, so no growth per stage.
    assign new_a.im = DATA_W'(sum_im >>> 1);
    assign new_b.re = DATA_W'(dif_re >>> 1);
    assign new_b.im = DATA_W'(dif_im >>> 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            stage_q <= '0;
            pair_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (ctrl.start) begin
                        stage_q <= ctrl.stage;
                        pair_q  <= '0;
                        state_q <= S_RDA;
                    end else if (ctrl.host_req) begin
                        state_q <= ctrl.host_we ? S_HWR1 : S_HRD1;
                    end
                end
                S_RDA:  state_q <= S_RDB;
                S_RDB:  state_q <= S_WAIT;
                S_WAIT: if (mem.pair_valid) state_q <= S_MUL;
                S_MUL:  state_q <= S_WR1;
                S_WR1:  state_q <= S_WR2;
                S_WR2: begin
                    pair_q  <= pair_q + 1'b1;
                    state_q <= (pair_q == '1) ? S_IDLE : S_RDA;
                end
                S_HWR1: state_q <= S_HWR2;
                S_HWR2: state_q <= S_IDLE;
                S_HRD1: state_q <= S_HRD2;
                S_HRD2: state_q <= S_HRDV;
                S_HRDV: if (mem.pair_valid) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_WAIT && mem.pair_valid) begin
            a_q <= mem.rd_pair_a;
            b_q <= mem.rd_pair_b;
        end
        if (state_q == S_MUL) begin
            t_re_q <= T_W'(pr_re >>> (DATA_W - 1));  // Back to Q1.15, truncated.
            t_im_q <= T_W'(pr_im >>> (DATA_W - 1));
        end
    end

    // ********************************************************************
    // Memory port, shared by the stage and the host.
    // ********************************************************************
    assign stage_run = state_q inside {S_RDA, S_RDB, S_WAIT, S_MUL, S_WR1, S_WR2};

    assign mem.rd_en     = state_q inside {S_RDA, S_RDB, S_HRD1, S_HRD2};
    assign mem.rd_addr   = (state_q == S_RDA) ? addr_a :
                           (state_q == S_RDB) ? addr_b : ctrl.host_addr;
    assign mem.wr_start  = (state_q == S_WR1) || (state_q == S_HWR1);
    assign mem.wr_addr_a = stage_run ? addr_a : ctrl.host_addr;
    assign mem.wr_addr_b = stage_run ? addr_b : ctrl.host_addr;  // Host writes a and b alike.
    assign mem.wr_data_a = stage_run ? new_a : ctrl.host_wdata;
    assign mem.wr_data_b = stage_run ? new_b : ctrl.host_wdata;

    assign ctrl.busy       = stage_run;
    assign ctrl.host_ack   = (state_q == S_HWR1) || (state_q == S_HRDV && mem.pair_valid);
    assign ctrl.host_rdata = mem.rd_pair_a;

    assign bfly_done_o = (state_q == S_WR2);
    assign stage_end_o = bfly_done_o && (pair_q == '1);

    // The two write addresses differ only in the stage bit.
    a_pair_distinct: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == S_WR1) |-> ((mem.wr_addr_a ^ mem.wr_addr_b) == half));

endmodule

// File: verilog/stage_result.sv
`timescale 1ns/1ps

module stage_result import fft_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_i,
    input  logic             bfly_done_i,
    input  logic             stage_end_i,
    input  logic             clr_done_i,
    output logic             done_o,
    output logic [CNT_W-1:0] bfly_count_o,
    output logic             irq_o
);

    logic [CNT_W-1:0] count_q;
    logic             done_q;

    // Butterflies finished in the current stage.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            count_q <= '0;
        else if (start_i)
            count_q <= '0;
        else if (bfly_done_i)
            count_q <= count_q + 1'b1;
    end

    // ********************************************************************
    // Sticky done flag.
    // ********************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (stage_end_i) begin
            done_q <= 1'b1;
        end else if (start_i || clr_done_i) begin
            done_q <= 1'b0;                          // New stage or host clear.
        end
    end

    assign done_o       = done_q;
    assign bfly_count_o = count_q;
    assign irq_o        = done_q;

    // The eighth butterfly of a stage closes it.
    a_end_with_bfly: assert property (@(posedge clk) disable iff (!rst_n)
        stage_end_i |-> (bfly_done_i && count_q == CNT_W'(N_POINTS / 2 - 1)));

endmodule

// File: verilog/fft_stage_top.sv
`timescale 1ns/1ps

module fft_stage_top import fft_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [WB_ADR_W-1:0] wb_adr_i,
    input  logic [WB_DAT_W-1:0] wb_dat_i,
    output logic [WB_DAT_W-1:0] wb_dat_o,
    output logic                wb_ack_o,
    output logic                irq_o
);

    logic             done;
    logic [CNT_W-1:0] bfly_count;
    logic             clr_done;
    logic             bfly_done;
    logic             stage_end;

    stage_ctrl_if ctrl_bus ();

    // Bus decode.
    fft_wb_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .ctrl         (ctrl_bus),
        .done_i       (done),
        .bfly_count_i (bfly_count),
        .clr_done_o   (clr_done)
    );

    // Butterfly engine with its sample memory.
    bfly_execute u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl_bus),
        .bfly_done_o (bfly_done),
        .stage_end_o (stage_end)
    );

    stage_result u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (ctrl_bus.start),
        .bfly_done_i  (bfly_done),
        .stage_end_i  (stage_end),
        .clr_done_i   (clr_done),
        .done_o       (done),
        .bfly_count_o (bfly_count),
        .irq_o        (irq_o)
    );

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;                  // 100 ns period.
    end

    // Reset held low for the first two rising edges.
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: test/tb_fft_stage.sv
`timescale 1ns/1ps

module tb_fft_stage import fft_pkg::*; ();

    // About four times the cycles that all tests take together.
    localparam int TIMEOUT_CYCLES = 20000;

    logic                clk;
    logic                rst_n;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [WB_DAT_W-1:0] wb_dat;
    logic [WB_DAT_W-1:0] wb_dat_out;
    logic                wb_ack;
    logic                irq;
    integer              seed;
    int                  cycle_count;
    int                  err_count;
    cplx_t               model_mem [N_POINTS];   // Expected sample memory.

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fft_stage_top u_fft_stage_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat),
        .wb_dat_o (wb_dat_out),
        .wb_ack_o (wb_ack),
        .irq_o    (irq)
    );

    // ********************************************************************
    // Error handling and timeout.
    // ********************************************************************
    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout reached after %0d cycles, the tests did not finish.",
                     cycle_count);
            stop_run();
        end
    end

    task automatic check_sample(input string name, input cplx_t got, input cplx_t exp);
        if (got !== exp) begin
            err_count++;
            $display("FAIL at %0t: %s got re=%0d im=%0d expected re=%0d im=%0d",
                     $time, name, got.re, got.im, exp.re, exp.im);
            stop_run();
        end
    endtask

    task automatic check_status(input logic [WB_DAT_W-1:0] got,
                                input logic [WB_DAT_W-1:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("FAIL at %0t: STATUS got %h expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_count++;
            $display("FAIL at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // ********************************************************************
    // Wishbone classic master.
    // ********************************************************************
    task automatic wait_ack();
        @(posedge clk);
        while (wb_ack !== 1'b1)
            @(posedge clk);
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b1;
        wb_adr <= adr;
        wb_dat <= dat;
        wait_ack();
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] dat);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_ack();
        dat = wb_dat_out;                            // Stable while ack is high.
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // ********************************************************************
    // Reference model of one butterfly pass.
    // ********************************************************************
    task automatic model_stage(input int s);
        int     p;
        int     half;
        int     k;
        int     ia;
        int     ib;
        int     j;
        longint c;
        longint sn;
        longint ar;
        longint ai;
        longint br;
        longint bi;
        longint tr;
        longint ti;
        half = 1 << s;
        for (p = 0; p < N_POINTS / 2; p++) begin
            k  = p % half;
            ia = (p / half) * 2 * half + k;
            ib = ia + half;
            j  = k * 8 / half;
            c  = TW_COS[j];
            sn = TW_SIN[j];
            ar = model_mem[ia].re;
            ai = model_mem[ia].im;
            br = model_mem[ib].re;
            bi = model_mem[ib].im;
            tr = (c * br + sn * bi) >>> 15;          // W = c - i*sn.
            ti = (c * bi - sn * br) >>> 15;
            model_mem[ia].re = DATA_W'((ar + tr) >>> 1);
            model_mem[ia].im = DATA_W'((ai + ti) >>> 1);
            model_mem[ib].re = DATA_W'((ar - tr) >>> 1);
            model_mem[ib].im = DATA_W'((ai - ti) >>> 1);
        end
    endtask

    // ********************************************************************
    // Helpers for sample loads and stage runs.
    // ********************************************************************
    task automatic write_all_samples();
        for (int i = 0; i < N_POINTS; i++)
            wb_write(WB_ADR_W'(i), model_mem[i]);
    endtask

    task automatic load_random();
        for (int i = 0; i < N_POINTS; i++)
            model_mem[i] = $random(seed);
        write_all_samples();
    endtask

    task automatic check_all_samples();
        logic [WB_DAT_W-1:0] dat;
        for (int i = 0; i < N_POINTS; i++) begin
            wb_read(WB_ADR_W'(i), dat);
            check_sample($sformatf("sample[%0d]", i), dat, model_mem[i]);
        end
    endtask

    task automatic wait_done();
        logic [WB_DAT_W-1:0] status;
        status = '0;
        while (status[1] !== 1'b1)
            wb_read(ADR_STATUS, status);             // Poll until done.
    endtask

    task automatic run_stage(input logic [STAGE_W-1:0] s);
        wb_write(ADR_CTRL, WB_DAT_W'({s, 1'b1}));
        wait_done();
    endtask

    // ********************************************************************
    // Directed tests.
    // ********************************************************************
    task automatic test_reset_idle();
        logic [WB_DAT_W-1:0] status;
        wb_read(ADR_STATUS, status);
        check_status(status, 32'h0);
        check_bit("irq_o", irq, 1'b0);
    endtask

    task automatic test_write_readback();
        load_random();
        check_all_samples();
    endtask

    task automatic test_stage_known();
        for (int i = 0; i < N_POINTS; i++)
            model_mem[i] = '0;
        model_mem[0].re = 16'sd16384;                // Impulse at sample 0.
        write_all_samples();
        run_stage(2'd0);
        model_stage(0);
        check_all_samples();
        for (int s = 1; s < 4; s++) begin
            load_random();
            run_stage(STAGE_W'(s));
            model_stage(s);
            check_all_samples();
        end
    endtask

    task automatic test_completion();
        logic [WB_DAT_W-1:0] status;
        load_random();
        wb_write(ADR_CTRL, WB_DAT_W'({2'd1, 1'b1}));
        wb_read(ADR_STATUS, status);
        check_status(status, 32'h0000_0001);         // Busy, nothing done yet.
        wait_done();
        wb_read(ADR_STATUS, status);
        check_status(status, 32'h0000_0082);         // Eight butterflies and done.
        check_bit("irq_o", irq, 1'b1);
        wb_write(ADR_STATUS, 32'h1);
        wb_read(ADR_STATUS, status);
        check_status(status, 32'h0000_0080);
        check_bit("irq_o", irq, 1'b0);
    endtask

    task automatic test_backpressure();
        cplx_t host_val;
        load_random();
        host_val = $random(seed);
        wb_write(ADR_CTRL, WB_DAT_W'({2'd2, 1'b1}));
        wb_write(WB_ADR_W'(5), host_val);            // Held off until the stage ends.
        check_bit("irq_o", irq, 1'b1);
        model_stage(2);
        model_mem[5] = host_val;
        check_all_samples();
        wb_write(ADR_STATUS, 32'h1);
    endtask

    task automatic test_full_transform();
        load_random();
        for (int s = 0; s < 4; s++) begin
            run_stage(STAGE_W'(s));
            model_stage(s);
        end
        check_all_samples();
    endtask

    initial begin
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat      = '0;
        seed        = 32'haacfa5aa;
        cycle_count = 0;
        err_count   = 0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        test_reset_idle();
        test_write_readback();
        test_stage_known();
        test_completion();
        test_backpressure();
        test_full_transform();
        if (err_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: filelist.f
verilog/fft_pkg.sv
verilog/pair_mem_if.sv
verilog/stage_ctrl_if.sv
verilog/fft_wb_decode.sv
verilog/pair_ram.sv
verilog/bfly_execute.sv
verilog/stage_result.sv
verilog/fft_stage_top.sv
test/tb_clk_gen.sv
test/tb_fft_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the FFT stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fft_stage -f filelist.f

./obj_dir/Vtb_fft_stage 2>&1 | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
